/* crc_accum.sv */
//------------------------------------------------------------
// running CRC state and result logic of the H2C checker
// feeds the seed into the chain, stores the chain result for
// every beat and, on the last beat of a packet, compares it
// with the received CRC. results appear one cycle after step
//------------------------------------------------------------
module crc_accum (
   input  logic                              axi_aclk,
   input  logic                              axi_aresetn,
   input  h2c_crc_pkg::crc_step_t            step,
   input  logic [h2c_crc_pkg::crc_width-1:0] crc_next,
   input  logic                              clr_match,
   output logic [h2c_crc_pkg::crc_width-1:0] crc_seed,
   output logic                              crc_match,
   output logic                              pkt_done,
   output logic [15:0]                       err_count
);

   import h2c_crc_pkg::*;

   logic [crc_width-1:0] crc_reg;
   logic                 sop;
   logic                 step_eop;
   logic                 crc_equal;

   //------------------------------------------------------------
   // seed selection
   //------------------------------------------------------------
   // all ones at the start of every packet
   assign crc_seed = sop ? {crc_width{1'b1}} : crc_reg;

   assign step_eop  = step.valid && step.last;
   assign crc_equal = (crc_next == step.rx_crc);

   // running value and packet boundary tracking
   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         crc_reg <= '0;
         sop     <= 1'b1;
      end else if (step.valid) begin
         crc_reg <= crc_next;
         sop     <= step.last;
      end
   end

   //------------------------------------------------------------
   // packet result
   //------------------------------------------------------------
   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         pkt_done <= 1'b0;
      end else begin
         pkt_done <= step_eop;
      end
   end

   // sticky match flag, a clear beats a compare in the same cycle
   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         crc_match <= 1'b0;
      end else if (clr_match) begin
         crc_match <= 1'b0;
      end else if (step_eop) begin
         crc_match <= crc_equal;
      end
   end

   // mismatch counter, holds at full scale
   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         err_count <= '0;
      end else if (step_eop && !crc_equal && err_count != 16'hffff) begin
         err_count <= err_count + 16'd1;
      end
   end

endmodule

/* crc_chunk_stage.sv */
//------------------------------------------------------------
// one link of the combinational CRC-32 chain
// folds a 32-bit data slice into the incoming CRC as 32
// serial LFSR steps, data msb first. instances are chained
// so that the whole beat is covered in one cycle
//------------------------------------------------------------
module crc_chunk_stage (
   input  logic [h2c_crc_pkg::chunk_width-1:0] data,
   input  logic [h2c_crc_pkg::crc_width-1:0]   crc_in,
   output logic [h2c_crc_pkg::crc_width-1:0]   crc_out
);

   import h2c_crc_pkg::*;

   logic [crc_width-1:0] crc_var;
   logic                 fb;

   always_comb begin
      crc_var = crc_in;
      fb      = 1'b0;
      for (int i = chunk_width - 1; i >= 0; i--) begin
         // feedback is crc msb xor the next data bit
         fb      = crc_var[crc_width-1] ^ data[i];
         crc_var = {crc_var[crc_width-2:0], 1'b0} ^ (crc_poly & {crc_width{fb}});
      end
      crc_out = crc_var;
   end

endmodule

/* h2c_beat_capture.sv */
//------------------------------------------------------------
// input register stage of the H2C checker
// takes one beat per beat_valid strobe, zeroes the empty
// bytes of a last beat and hands the result to the CRC chain
// one cycle later. also holds the qid of the last packet
//------------------------------------------------------------
module h2c_beat_capture (
   input  logic                              axi_aclk,
   input  logic                              axi_aresetn,
   input  h2c_crc_pkg::h2c_beat_t            beat_in,
   input  logic                              beat_valid,
   output h2c_crc_pkg::crc_step_t            step,
   output logic [h2c_crc_pkg::qid_width-1:0] h2c_qid
);

   import h2c_crc_pkg::*;

   logic [h2c_data_width-1:0] data_masked;

   //------------------------------------------------------------
   // empty-byte masking
   //------------------------------------------------------------
   // byte b counts up from the lsb, the empty bytes sit at the top
   always_comb begin
      data_masked = beat_in.data;
      if (beat_in.last) begin
         for (int b = 0; b < h2c_bytes; b++) begin
            if (b >= h2c_bytes - int'(beat_in.mty)) begin
               data_masked[b*8 +: 8] = 8'h00;
            end
         end
      end
   end

   //------------------------------------------------------------
   // beat register
   //------------------------------------------------------------
   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         step.valid <= 1'b0;
      end else begin
         step.valid <= beat_valid;
      end
   end

   // payload only, qualified downstream by step.valid
   always_ff @(posedge axi_aclk) begin
      step.data   <= data_masked;
      step.last   <= beat_in.last;
      step.rx_crc <= beat_in.crc;
   end

   // queue id of the most recent completed packet
   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         h2c_qid <= '0;
      end else if (beat_valid && beat_in.last) begin
         h2c_qid <= beat_in.qid;
      end
   end

endmodule

/* h2c_crc_check_sva.sv */
//------------------------------------------------------------
// concurrent checks on the H2C checker top level
// bound into h2c_crc_check_top, reports only through $error
//------------------------------------------------------------
module h2c_crc_check_sva (
   input logic                              axi_aclk,
   input logic                              axi_aresetn,
   input h2c_crc_pkg::h2c_beat_t            beat_in,
   input logic                              beat_valid,
   input logic                              clr_match,
   input logic [h2c_crc_pkg::qid_width-1:0] h2c_qid,
   input logic                              crc_match,
   input logic                              pkt_done,
   input logic [15:0]                       err_count
);

   import h2c_crc_pkg::*;

   // number of failed checks so far
   int assert_fails = 0;

   // single-cycle result pulse
   done_one_cycle: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                                    pkt_done |=> !pkt_done)
      else begin
         assert_fails++;
         $error("pkt_done high for two cycles in a row");
      end

   done_after_last: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                                     beat_valid && beat_in.last |-> ##2 pkt_done)
      else begin
         assert_fails++;
         $error("pkt_done missing two cycles after a last beat");
      end

   clear_drops_match: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                                       clr_match |=> !crc_match)
      else begin
         assert_fails++;
         $error("crc_match still high after clr_match");
      end

   // counter moves only together with a failed compare
   errs_on_mismatch: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                                      !$stable(err_count) |-> pkt_done && !crc_match)
      else begin
         assert_fails++;
         $error("err_count changed without a mismatched packet");
      end

   qid_follows_last: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
                                      beat_valid && beat_in.last |=>
                                      h2c_qid == $past(beat_in.qid))
      else begin
         assert_fails++;
         $error("h2c_qid does not hold the qid of the last beat");
      end

endmodule

bind h2c_crc_check_top h2c_crc_check_sva u_sva (.*);

/* h2c_crc_check_top.sv */
//------------------------------------------------------------
// top level of the H2C receive CRC checker
// beat capture feeds a chain of CRC chunk stages, the
// accumulator closes the loop and produces the packet result.
// beats arrive as single-cycle strobes without back-pressure
//------------------------------------------------------------
module h2c_crc_check_top (
   input  logic                              axi_aclk,
   input  logic                              axi_aresetn,
   input  h2c_crc_pkg::h2c_beat_t            beat_in,
   input  logic                              beat_valid,
   input  logic                              clr_match,
   output logic [h2c_crc_pkg::qid_width-1:0] h2c_qid,
   output logic                              crc_match,
   output logic                              pkt_done,
   output logic [15:0]                       err_count
);

   import h2c_crc_pkg::*;

   crc_step_t            step;
   // crc_chain[0] is the seed, crc_chain[n_chunks] the beat result
   logic [crc_width-1:0] crc_chain [0:n_chunks];

   //------------------------------------------------------------
   // input register
   //------------------------------------------------------------
   h2c_beat_capture u_capture (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn),
      .beat_in     (beat_in),
      .beat_valid  (beat_valid),
      .step        (step),
      .h2c_qid     (h2c_qid)
   );

   //------------------------------------------------------------
   // CRC chain, slice 0 is the top of the beat
   //------------------------------------------------------------
   for (genvar k = 0; k < n_chunks; k++) begin : g_chunk
      crc_chunk_stage u_stage (
         .data    (step.data[h2c_data_width-1-k*chunk_width -: chunk_width]),
         .crc_in  (crc_chain[k]),
         .crc_out (crc_chain[k+1])
      );
   end

   //------------------------------------------------------------
   // running CRC and result
   //------------------------------------------------------------
   crc_accum u_accum (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn),
      .step        (step),
      .crc_next    (crc_chain[n_chunks]),
      .clr_match   (clr_match),
      .crc_seed    (crc_chain[0]),
      .crc_match   (crc_match),
      .pkt_done    (pkt_done),
      .err_count   (err_count)
   );

endmodule

/* h2c_crc_pkg.sv */
//------------------------------------------------------------
// shared widths, CRC constants and beat structs for the H2C
// receive checker. every design file imports this package
// inside its body and uses scoped names in its port list
//------------------------------------------------------------
package h2c_crc_pkg;

   //------------------------------------------------------------
   // stream geometry
   //------------------------------------------------------------
   localparam int h2c_data_width = 256;
   localparam int h2c_bytes      = h2c_data_width / 8;
   // empty-byte count covers 0 .. h2c_bytes-1
   localparam int mty_width      = $clog2(h2c_bytes);
   localparam int qid_width      = 11;

   //------------------------------------------------------------
   // CRC-32 settings
   //------------------------------------------------------------
   localparam int crc_width   = 32;
   // slice width folded by one chain stage
   localparam int chunk_width = 32;
   localparam int n_chunks    = h2c_data_width / chunk_width;

   // normal form, msb first, no reflection
   localparam logic [crc_width-1:0] crc_poly = 32'h04c1_1db7;

   // one beat as delivered by the stream, crc only valid with last
   typedef struct packed {
      logic [h2c_data_width-1:0] data;
      logic                      last;
      logic [mty_width-1:0]      mty;
      logic [crc_width-1:0]      crc;
      logic [qid_width-1:0]      qid;
   } h2c_beat_t;

   // registered beat after the empty bytes are zeroed
   typedef struct packed {
      logic                      valid;
      logic [h2c_data_width-1:0] data;
      logic                      last;
      logic [crc_width-1:0]      rx_crc;
   } crc_step_t;

endpackage

/* tb_clock_gen.sv */
//------------------------------------------------------------
// testbench clock and reset source
// free-running clock, reset held low for a number of rising
// edges and released on a falling edge
//------------------------------------------------------------
module tb_clock_gen #(
   parameter int half_period  = 5,
   parameter int reset_cycles = 3
) (
   output logic axi_aclk,
   output logic axi_aresetn
);

   initial begin
      axi_aclk = 1'b0;
      forever #(half_period) axi_aclk = ~axi_aclk;
   end

   initial begin
      axi_aresetn = 1'b0;
      repeat (reset_cycles) @(posedge axi_aclk);
      @(negedge axi_aclk);
      axi_aresetn = 1'b1;
   end

endmodule

/* tb_h2c_crc_check.sv */
//------------------------------------------------------------
// testbench for the H2C receive CRC checker
// drives packets on the falling edge, builds the received CRC
// with a bit-serial reference model and checks the packet
// results with immediate assertions. one line per test
//------------------------------------------------------------
module tb_h2c_crc_check;

   import h2c_crc_pkg::*;

   localparam int n_tests         = 6;
   localparam int max_test_cycles = 40;
   // eightfold margin on all tests plus reset
   localparam int cycle_limit     = n_tests * max_test_cycles * 8 + 80;
   localparam logic [31:0] ref_poly = 32'h04c1_1db7;

   logic                 axi_aclk;
   logic                 axi_aresetn;
   h2c_beat_t            beat_in;
   logic                 beat_valid;
   logic                 clr_match;
   logic [qid_width-1:0] h2c_qid;
   logic                 crc_match;
   logic                 pkt_done;
   logic [15:0]          err_count;

   integer      seed = 32'h9f4e_fa62;
   int          cycle_count = 0;
   int          errors = 0;
   int          errs_at_start = 0;
   int          test_num = 0;
   int          pass_count = 0;
   int          fail_count = 0;
   int          exp_errs = 0;
   logic        got_match;
   logic [15:0] got_errs;
   logic        done_match [$];
   logic [15:0] done_errs [$];

   tb_clock_gen #(.half_period(5), .reset_cycles(3)) u_clk (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn)
   );

   h2c_crc_check_top dut0 (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn),
      .beat_in     (beat_in),
      .beat_valid  (beat_valid),
      .clr_match   (clr_match),
      .h2c_qid     (h2c_qid),
      .crc_match   (crc_match),
      .pkt_done    (pkt_done),
      .err_count   (err_count)
   );

   //------------------------------------------------------------
   // reference model
   //------------------------------------------------------------
   function automatic logic [31:0] ref_crc_beat(logic [31:0] crc_start,
                                                logic [h2c_data_width-1:0] data);
      logic [31:0] crc;
      logic        msb;
      crc = crc_start;
      for (int i = h2c_data_width - 1; i >= 0; i--) begin
         msb = crc[31];
         crc = crc << 1;
         if (msb ^ data[i]) crc = crc ^ ref_poly;
      end
      return crc;
   endfunction

   // empty bytes are the top mty bytes of the beat
   function automatic logic [h2c_data_width-1:0] zero_empty_bytes(
      logic [h2c_data_width-1:0] data, int mty);
      logic [h2c_data_width-1:0] d;
      d = data;
      for (int j = 0; j < mty; j++) d[h2c_data_width-1-8*j -: 8] = 8'h00;
      return d;
   endfunction

   function automatic logic [h2c_data_width-1:0] random_beat_data();
      logic [h2c_data_width-1:0] d;
      for (int w = 0; w < h2c_data_width / 32; w++) d[w*32 +: 32] = $random(seed);
      return d;
   endfunction

   //------------------------------------------------------------
   // stimulus and result collection
   //------------------------------------------------------------
   task automatic drive_packet(input int nbeats, input int mty,
                               input logic [qid_width-1:0] qid, input logic corrupt);
      logic [h2c_data_width-1:0] raw;
      logic [31:0]               crc;
      logic                      is_last;
      int                        flip;
      crc = 32'hffff_ffff;
      for (int i = 0; i < nbeats; i++) begin
         is_last = (i == nbeats - 1);
         raw     = random_beat_data();
         crc     = ref_crc_beat(crc, is_last ? zero_empty_bytes(raw, mty) : raw);
         flip    = $unsigned($random(seed)) % 32;
         @(negedge axi_aclk);
         beat_valid   = 1'b1;
         beat_in.data = raw;
         beat_in.last = is_last;
         beat_in.mty  = is_last ? mty_width'(mty) : '0;
         beat_in.qid  = qid;
         if (is_last) beat_in.crc = corrupt ? (crc ^ (32'h1 << flip)) : crc;
         else beat_in.crc = $random(seed);
      end
   endtask

   task automatic idle_inputs();
      @(negedge axi_aclk);
      beat_valid = 1'b0;
      clr_match  = 1'b0;
   endtask

   task automatic collect_result(output logic match, output logic [15:0] errs);
      int waited;
      waited = 0;
      while (done_match.size() == 0 && waited < max_test_cycles) begin
         @(negedge axi_aclk);
         waited++;
      end
      if (done_match.size() == 0) begin
         $display("no pkt_done seen within %0d cycles", max_test_cycles);
         errors++;
         match = 1'bx;
         errs  = 'x;
      end else begin
         match = done_match.pop_front();
         errs  = done_errs.pop_front();
      end
   endtask

   // outputs settle after the rising edge, so sample on the falling one
   always @(negedge axi_aclk) begin
      if (axi_aresetn && pkt_done) begin
         done_match.push_back(crc_match);
         done_errs.push_back(err_count);
      end
   end

   task automatic check_eq(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
      assert (got === exp)
      else begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic start_test();
      test_num++;
      errs_at_start = errors;
   endtask

   task automatic end_test(input string name);
      if (errors == errs_at_start) begin
         pass_count++;
         $display("test %0d %s: ok", test_num, name);
      end else begin
         fail_count++;
         $display("test %0d %s: %0d error(s)", test_num, name, errors - errs_at_start);
      end
   endtask

   //------------------------------------------------------------
   // watchdog
   //------------------------------------------------------------
   always @(posedge axi_aclk) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("run stopped, cycle limit of %0d reached", cycle_limit);
         $display("test failed");
         $finish;
      end
   end

   //------------------------------------------------------------
   // test sequence
   //------------------------------------------------------------
   initial begin
      beat_valid = 1'b0;
      beat_in    = '0;
      clr_match  = 1'b0;
      @(posedge axi_aresetn);
      @(negedge axi_aclk);

      start_test();
      check_eq("crc_match", crc_match, 0);
      check_eq("pkt_done", pkt_done, 0);
      check_eq("err_count", err_count, 0);
      check_eq("h2c_qid", h2c_qid, 0);
      end_test("reset values");

      start_test();
      drive_packet(1, 0, 11'h012, 1'b0);
      idle_inputs();
      collect_result(got_match, got_errs);
      check_eq("crc_match", got_match, 1);
      check_eq("err_count", got_errs, exp_errs);
      end_test("single beat packet");

      // garbage in the empty bytes must not reach the CRC
      start_test();
      drive_packet(3, 1 + $unsigned($random(seed)) % (h2c_bytes - 1), 11'h145, 1'b0);
      idle_inputs();
      collect_result(got_match, got_errs);
      check_eq("crc_match", got_match, 1);
      check_eq("err_count", got_errs, exp_errs);
      end_test("three beats with empty bytes");

      start_test();
      drive_packet(2, 4, 11'h0e7, 1'b1);
      idle_inputs();
      exp_errs++;
      collect_result(got_match, got_errs);
      check_eq("crc_match", got_match, 0);
      check_eq("err_count", got_errs, exp_errs);
      end_test("corrupted crc");

      start_test();
      drive_packet(1, 0, 11'h233, 1'b0);
      idle_inputs();
      collect_result(got_match, got_errs);
      check_eq("crc_match before clear", got_match, 1);
      @(negedge axi_aclk);
      clr_match = 1'b1;
      idle_inputs();
      check_eq("crc_match after clear", crc_match, 0);
      check_eq("err_count after clear", err_count, exp_errs);
      end_test("match clear");

      // second packet starts right after the first, and is corrupted
      start_test();
      drive_packet(3, 7, 11'h2a5, 1'b0);
      drive_packet(2, 0, 11'h5c3, 1'b1);
      idle_inputs();
      collect_result(got_match, got_errs);
      check_eq("first packet crc_match", got_match, 1);
      check_eq("first packet err_count", got_errs, exp_errs);
      exp_errs++;
      collect_result(got_match, got_errs);
      check_eq("second packet crc_match", got_match, 0);
      check_eq("second packet err_count", got_errs, exp_errs);
      check_eq("h2c_qid", h2c_qid, 11'h5c3);
      end_test("back to back packets");

      $display("tests run %0d, pass %0d, fail %0d, assertion failures %0d",
               test_num, pass_count, fail_count, dut0.u_sva.assert_fails);
      if (fail_count == 0 && dut0.u_sva.assert_fails == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
h2c_crc_pkg.sv
h2c_beat_capture.sv
crc_chunk_stage.sv
crc_accum.sv
h2c_crc_check_top.sv
h2c_crc_check_sva.sv
tb_clock_gen.sv
tb_h2c_crc_check.sv
